//--- common/hmc_pkg.sv
// --------------------------------------------------
// Shared HMC widths, command codes, FLIT control and
// response slice structs, request header builder
// --------------------------------------------------

`default_nettype none

package hmc_pkg;

  // --------------------------------------------------
  // Datapath widths
  // --------------------------------------------------
  // One FLIT is 128 bits, four FLITs per stream word
  localparam int FLIT_W = 128;
  localparam int FPW    = 4;
  localparam int BUS_W  = FPW * FLIT_W;

  // User side widths
  // Address counts 32-byte units
  localparam int ADDR_W = 27;
  localparam int TAG_W  = 9;
  localparam int DATA_W = 256;

  // --------------------------------------------------
  // Request commands and packet lengths
  // --------------------------------------------------
  // Posted 32-byte write, no response returned
  localparam logic [5:0] CMD_P_WR32 = 6'b011001;
  // 32-byte read, answered by RD_RS
  localparam logic [5:0] CMD_RD32   = 6'b110001;

  // Lengths in FLITs, header and tail included
  localparam logic [3:0] LNG_WR = 4'd3;
  localparam logic [3:0] LNG_RD = 4'd1;

  // Posted writes never get a response, so one tag serves all
  localparam logic [TAG_W-1:0] WR_TAG = 9'd1;

  // Tag field inside a request or response header
  localparam int HDR_TAG_LSB = 15;
  localparam int HDR_TAG_MSB = 23;

  // --------------------------------------------------
  // Stream sideband and internal slice
  // --------------------------------------------------
  // TUSER layout, bit n of each field belongs to lane n
  // Tail in [11:8], head in [7:4], valid in [3:0]
  typedef struct packed {
    logic [FPW-1:0] tail;
    logic [FPW-1:0] head;
    logic [FPW-1:0] valid;
  } flit_ctrl_t;

  // What the locator found in one receive word
  typedef struct packed {
    logic              head_found;
    logic [1:0]        head_lane;
    logic              complete;
    logic              cont;
    logic [TAG_W-1:0]  tag;
    // Right-aligned, unused upper bits are zero
    logic [DATA_W-1:0] data;
  } rsp_slice_t;

  // Request header
  // CUB and RES zero, ADDR[33:0] is {2'b00, addr, 5'b0}
  // LNG repeated in DLN, bit 6 reserved zero
  function automatic logic [63:0] hmc_req_header(
    input logic [5:0]        cmd,
    input logic [3:0]        lng,
    input logic [ADDR_W-1:0] addr,
    input logic [TAG_W-1:0]  tag
  );
    logic [33:0] byte_addr;
    byte_addr = {2'b00, addr, 5'b00000};
    return {3'b000, 3'b000, byte_addr, tag, lng, lng, 1'b0, cmd};
  endfunction

endpackage

`default_nettype wire

//--- tx/hmc_req_packer.sv
// --------------------------------------------------
// Request packer: startup wait, write and read
// acceptance, held transmit word
// --------------------------------------------------

`default_nettype none

module hmc_req_packer #(
  parameter int START_WAIT_LOG2 = 8
) (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            post_done_i,
  // Write side
  input  wire                            wr_req_i,
  input  wire [hmc_pkg::ADDR_W-1:0]      wr_addr_i,
  input  wire [hmc_pkg::DATA_W-1:0]      wr_data_i,
  output logic                           wr_ready_o,
  // Read side
  input  wire                            rd_req_i,
  input  wire [hmc_pkg::ADDR_W-1:0]      rd_addr_i,
  input  wire [hmc_pkg::TAG_W-1:0]       tag_i,
  output logic                           rd_ready_o,
  // Transmit stream
  output logic                           tx_tvalid_o,
  input  wire                            tx_tready_i,
  output logic [hmc_pkg::BUS_W-1:0]      tx_tdata_o,
  output hmc_pkg::flit_ctrl_t            tx_tuser_o
);

  // Top bit of the counter marks the end of the wait
  logic [START_WAIT_LOG2:0]   wait_cnt;
  logic                       start_done;
  logic                       slot_free;
  logic                       wr_acc;
  logic                       rd_acc;
  logic [63:0]                wr_hdr;
  logic [63:0]                rd_hdr;
  logic [hmc_pkg::BUS_W-1:0]  word_d;
  hmc_pkg::flit_ctrl_t        user_d;

  // --------------------------------------------------
  // Startup wait after power-on done
  // --------------------------------------------------
  assign start_done = wait_cnt[START_WAIT_LOG2];

  always_ff @(posedge CLK) begin
    if (RST) begin
      wait_cnt <= '0;
    end else if (post_done_i && !start_done) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Register can take a new word when empty or draining this cycle
  assign slot_free  = !tx_tvalid_o || tx_tready_i;
  assign wr_ready_o = start_done && slot_free;
  assign rd_ready_o = start_done && slot_free;

  assign wr_acc = wr_req_i && wr_ready_o;
  assign rd_acc = rd_req_i && rd_ready_o;

  // --------------------------------------------------
  // Word packing
  // --------------------------------------------------
  assign wr_hdr = hmc_pkg::hmc_req_header(hmc_pkg::CMD_P_WR32, hmc_pkg::LNG_WR,
                                          wr_addr_i, hmc_pkg::WR_TAG);
  assign rd_hdr = hmc_pkg::hmc_req_header(hmc_pkg::CMD_RD32, hmc_pkg::LNG_RD,
                                          rd_addr_i, tag_i);

  always_comb begin
    word_d = '0;
    user_d = '0;
    // Write in lanes 0..2 with data straddling the header lane and the tail lane
    if (wr_acc) begin
      word_d[3*hmc_pkg::FLIT_W-1:0] = {64'd0, wr_data_i, wr_hdr};
      user_d.valid[2:0] = 3'b111;
      user_d.head[2:0]  = 3'b001;
      user_d.tail[2:0]  = 3'b100;
    end
    // Read header and zero tail in lane 3
    if (rd_acc) begin
      word_d[hmc_pkg::BUS_W-1:3*hmc_pkg::FLIT_W] = {64'd0, rd_hdr};
      user_d.valid[3] = 1'b1;
      user_d.head[3]  = 1'b1;
      user_d.tail[3]  = 1'b1;
    end
  end

  // Valid and sideband hold while the controller stalls
  always_ff @(posedge CLK) begin
    if (RST) begin
      tx_tvalid_o <= 1'b0;
      tx_tuser_o  <= '0;
    end else if (slot_free) begin
      tx_tvalid_o <= wr_acc || rd_acc;
      tx_tuser_o  <= user_d;
    end
  end

  always_ff @(posedge CLK) begin
    if (slot_free) begin
      tx_tdata_o <= word_d;
    end
  end

  // Stalled word must not move
  a_tx_hold : assert property (@(posedge CLK) disable iff (RST)
    tx_tvalid_o && !tx_tready_i |=>
      tx_tvalid_o && $stable(tx_tdata_o) && $stable(tx_tuser_o));

  // No request opens within the wait length after a reset
  a_no_early_ready : assert property (@(posedge CLK) disable iff (RST)
    (wr_ready_o || rd_ready_o) |-> !$past(RST, 1 << START_WAIT_LOG2));

endmodule

`default_nettype wire

//--- rx/hmc_rsp_locate.sv
// --------------------------------------------------
// Response locator: head and continuation matching
// on one receive word, tag and data extraction
// --------------------------------------------------

`default_nettype none

module hmc_rsp_locate (
  input  wire                          rx_tvalid_i,
  input  wire [hmc_pkg::BUS_W-1:0]     rx_tdata_i,
  input  hmc_pkg::flit_ctrl_t          rx_tuser_i,
  input  wire                          pending_i,
  output hmc_pkg::rsp_slice_t          slice_o
);

  logic [hmc_pkg::FPW-1:0]  v;
  logic [hmc_pkg::FPW-1:0]  h;
  logic [hmc_pkg::FPW-1:0]  t;
  logic                     head0_hit;
  logic                     head1_hit;
  logic                     head2_hit;
  logic                     head3_hit;
  logic                     cont2_hit;
  logic                     cont3_hit;
  logic [1:0]               lane;
  logic [63:0]              hdr;

  assign v = rx_tuser_i.valid;
  assign h = rx_tuser_i.head;
  assign t = rx_tuser_i.tail;

  // --------------------------------------------------
  // Pattern match
  // --------------------------------------------------
  // Heads at lanes 0 and 1 hold the whole response
  assign head0_hit = rx_tvalid_i && v[2:0] == 3'b111 && h[2:0] == 3'b001 &&
                     t[2:0] == 3'b100;
  assign head1_hit = rx_tvalid_i && v[3:1] == 3'b111 && h[3:1] == 3'b001 &&
                     t[3:1] == 3'b100;
  // Heads at lanes 2 and 3 run into the next word
  assign head2_hit = rx_tvalid_i && v[3:2] == 2'b11 && h[3:2] == 2'b01 &&
                     t[3:2] == 2'b00;
  assign head3_hit = rx_tvalid_i && v[3] && h[3] && !t[3];

  // Low lanes without a head only count while a head is waiting
  // Tail in lane 0 ends a lane 2 head
  assign cont2_hit = rx_tvalid_i && pending_i && v[0] && !h[0] && t[0];
  // Tail in lane 1 ends a lane 3 head
  assign cont3_hit = rx_tvalid_i && pending_i && v[1:0] == 2'b11 &&
                     h[1:0] == 2'b00 && t[1:0] == 2'b10;

  // Header lane for tag extraction
  always_comb begin
    if (head0_hit) begin
      lane = 2'd0;
    end else if (head1_hit) begin
      lane = 2'd1;
    end else if (head2_hit) begin
      lane = 2'd2;
    end else begin
      lane = 2'd3;
    end
  end

  assign hdr = rx_tdata_i[lane*hmc_pkg::FLIT_W +: 64];

  // --------------------------------------------------
  // Slice build
  // --------------------------------------------------
  // One event per word, a continuation wins over a new head
  always_comb begin
    slice_o = '0;
    if (cont2_hit) begin
      slice_o.cont      = 1'b1;
      slice_o.complete  = 1'b1;
      slice_o.data[63:0] = rx_tdata_i[63:0];
    end else if (cont3_hit) begin
      slice_o.cont        = 1'b1;
      slice_o.complete    = 1'b1;
      slice_o.data[191:0] = rx_tdata_i[191:0];
    end else if (head0_hit || head1_hit || head2_hit || head3_hit) begin
      slice_o.head_found = 1'b1;
      slice_o.head_lane  = lane;
      slice_o.tag        = hdr[hmc_pkg::HDR_TAG_MSB:hmc_pkg::HDR_TAG_LSB];
      // Data starts in the upper half of the header FLIT
      if (head0_hit || head1_hit) begin
        slice_o.complete = 1'b1;
        slice_o.data     = rx_tdata_i[lane*hmc_pkg::FLIT_W + 64 +: hmc_pkg::DATA_W];
      end else if (head2_hit) begin
        slice_o.data[191:0] = rx_tdata_i[hmc_pkg::BUS_W-1 -: 192];
      end else begin
        slice_o.data[63:0] = rx_tdata_i[hmc_pkg::BUS_W-1 -: 64];
      end
    end
  end

endmodule

`default_nettype wire

//--- rx/hmc_rsp_assemble.sv
// --------------------------------------------------
// Response assembler: partial head storage, merge
// with continuation, registered read data and tag
// --------------------------------------------------

`default_nettype none

module hmc_rsp_assemble (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            post_done_i,
  input  hmc_pkg::rsp_slice_t            slice_i,
  output logic                           pending_o,
  output logic                           rx_tready_o,
  output logic                           rsp_valid_o,
  output logic [hmc_pkg::DATA_W-1:0]     rsp_data_o,
  output logic [hmc_pkg::TAG_W-1:0]      rsp_tag_o
);

  logic                         armed;
  logic                         store;
  // Head at lane 3 keeps 64 bits, lane 2 keeps 192
  logic                         pend_lane3;
  logic [hmc_pkg::TAG_W-1:0]    part_tag;
  logic [191:0]                 part_data;
  logic [hmc_pkg::DATA_W-1:0]   merged;

  // Partial head waits for the next valid word
  assign store = armed && slice_i.head_found && !slice_i.complete;

  // Continuation bits go on top of the stored part
  assign merged = pend_lane3 ? {slice_i.data[191:0], part_data[63:0]} :
                               {slice_i.data[63:0], part_data};

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      armed       <= 1'b0;
      rx_tready_o <= 1'b0;
      pending_o   <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      rx_tready_o <= 1'b1;
      if (post_done_i) begin
        armed <= 1'b1;
      end
      rsp_valid_o <= armed && slice_i.complete;
      if (armed && slice_i.cont) begin
        pending_o <= 1'b0;
      end
      if (store) begin
        pending_o <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (store) begin
      part_tag   <= slice_i.tag;
      part_data  <= slice_i.data[191:0];
      pend_lane3 <= slice_i.head_lane == 2'd3;
    end
    if (armed && slice_i.complete) begin
      rsp_tag_o  <= slice_i.cont ? part_tag : slice_i.tag;
      rsp_data_o <= slice_i.cont ? merged : slice_i.data;
    end
  end

  // Locator and assembler must agree on the pending head
  a_cont_pending : assert property (@(posedge CLK) disable iff (RST)
    slice_i.cont |-> pending_o);

endmodule

`default_nettype wire

//--- verilog/hmc_user_top.sv
// --------------------------------------------------
// HMC user side top: request packer and response
// locator with assembler
// --------------------------------------------------

`default_nettype none

module hmc_user_top #(
  parameter int START_WAIT_LOG2 = 8
) (
  input  wire                           CLK,
  input  wire                           RST,
  input  wire                           post_done_i,
  // Write side
  input  wire                           wr_req_i,
  input  wire [hmc_pkg::ADDR_W-1:0]     wr_addr_i,
  input  wire [hmc_pkg::DATA_W-1:0]     wr_data_i,
  output logic                          wr_ready_o,
  // Read side
  input  wire                           rd_req_i,
  input  wire [hmc_pkg::ADDR_W-1:0]     rd_addr_i,
  input  wire [hmc_pkg::TAG_W-1:0]      tag_i,
  output logic                          rd_ready_o,
  // Transmit stream to the link controller
  output logic                          tx_tvalid_o,
  input  wire                           tx_tready_i,
  output logic [hmc_pkg::BUS_W-1:0]     tx_tdata_o,
  output hmc_pkg::flit_ctrl_t           tx_tuser_o,
  // Receive stream from the link controller
  input  wire                           rx_tvalid_i,
  output logic                          rx_tready_o,
  input  wire [hmc_pkg::BUS_W-1:0]      rx_tdata_i,
  input  hmc_pkg::flit_ctrl_t           rx_tuser_i,
  // Read response
  output logic                          rsp_valid_o,
  output logic [hmc_pkg::DATA_W-1:0]    rsp_data_o,
  output logic [hmc_pkg::TAG_W-1:0]     rsp_tag_o
);

  hmc_pkg::rsp_slice_t  rsp_slice;
  logic                 rsp_pending;

  // --------------------------------------------------
  // Transmit path
  // --------------------------------------------------
  hmc_req_packer #(
    .START_WAIT_LOG2 (START_WAIT_LOG2)
  ) i_hmc_req_packer (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done_i),
    .wr_req_i    (wr_req_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .wr_ready_o  (wr_ready_o),
    .rd_req_i    (rd_req_i),
    .rd_addr_i   (rd_addr_i),
    .tag_i       (tag_i),
    .rd_ready_o  (rd_ready_o),
    .tx_tvalid_o (tx_tvalid_o),
    .tx_tready_i (tx_tready_i),
    .tx_tdata_o  (tx_tdata_o),
    .tx_tuser_o  (tx_tuser_o)
  );

  // --------------------------------------------------
  // Receive path
  // --------------------------------------------------
  // Slice is combinational, registered once in the assembler
  hmc_rsp_locate i_hmc_rsp_locate (
    .rx_tvalid_i (rx_tvalid_i),
    .rx_tdata_i  (rx_tdata_i),
    .rx_tuser_i  (rx_tuser_i),
    .pending_i   (rsp_pending),
    .slice_o     (rsp_slice)
  );

  hmc_rsp_assemble i_hmc_rsp_assemble (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done_i),
    .slice_i     (rsp_slice),
    .pending_o   (rsp_pending),
    .rx_tready_o (rx_tready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_tag_o   (rsp_tag_o)
  );

endmodule

`default_nettype wire

//--- test/tb_hmc_user_tasks.svh
// --------------------------------------------------
// Directed tests, header and word builders, request
// and response drivers
// --------------------------------------------------

  // Random 256-bit payload from eight 32-bit draws
  function automatic logic [255:0] rand_data();
    logic [255:0] d;
    for (int i = 0; i < 8; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
    return d;
  endfunction

  // Header fields CMD [5:0], LNG [10:7], DLN [14:11], TAG [23:15], ADDR [57:24]
  function automatic logic [63:0] make_header(input logic [5:0] cmd, input logic [3:0] lng,
                                              input logic [26:0] addr, input logic [8:0] tag);
    logic [63:0] h;
    h        = '0;
    h[5:0]   = cmd;
    h[10:7]  = lng;
    h[14:11] = lng;
    h[23:15] = tag;
    // 32-byte units, so byte address bits 4..0 stay zero
    h[55:29] = addr;
    return h;
  endfunction

  // Expected posted write in lanes 0 to 2
  function automatic logic [511:0] write_word(input logic [26:0] addr, input logic [255:0] d);
    logic [511:0] w;
    w          = '0;
    w[63:0]    = make_header(hmc_pkg::CMD_P_WR32, 4'd3, addr, 9'd1);
    w[127:64]  = d[63:0];
    w[255:128] = d[191:64];
    w[319:256] = d[255:192];
    return w;
  endfunction

  // Expected read in lane 3, tail half zero
  function automatic logic [511:0] read_word(input logic [26:0] addr, input logic [8:0] tag);
    logic [511:0] w;
    w          = '0;
    w[447:384] = make_header(hmc_pkg::CMD_RD32, 4'd1, addr, tag);
    return w;
  endfunction

  // Present requests on a falling edge, hold until ready, drop one cycle later
  task automatic send_requests(input logic do_wr, input logic do_rd, input logic [26:0] wa,
                               input logic [255:0] wd, input logic [26:0] ra,
                               input logic [8:0] tag);
    wr_req  = do_wr;
    wr_addr = wa;
    wr_data = wd;
    rd_req  = do_rd;
    rd_addr = ra;
    rd_tag  = tag;
    while (!((wr_ready || !do_wr) && (rd_ready || !do_rd))) begin
      @(negedge CLK);
    end
    @(negedge CLK);
    wr_req = 1'b0;
    rd_req = 1'b0;
  endtask

  // Readies closed for 16 cycles of power-on done, then open
  task automatic test_startup();
    check_value(rx_tready, 1'b0, "rx_tready in reset");
    check_value(tx_tvalid, 1'b0, "tx_tvalid after reset");
    check_value(rsp_valid, 1'b0, "rsp_valid after reset");
    post_done = 1'b1;
    for (int i = 0; i < 16; i++) begin
      check_value(wr_ready, 1'b0, "wr_ready before startup wait");
      check_value(rd_ready, 1'b0, "rd_ready before startup wait");
      @(negedge CLK);
    end
    check_value(wr_ready, 1'b1, "wr_ready after startup wait");
    check_value(rd_ready, 1'b1, "rd_ready after startup wait");
    check_value(rx_tready, 1'b1, "rx_tready after reset");
  endtask

  task automatic test_write();
    logic [26:0]  a;
    logic [255:0] d;
    a = 27'($random(seed));
    d = rand_data();
    send_requests(1'b1, 1'b0, a, d, '0, '0);
    check_value(tx_tvalid, 1'b1, "write tx_tvalid");
    check_value(tx_tdata, write_word(a, d), "write tx_tdata");
    check_value(tx_tuser, 12'h417, "write tx_tuser");
    @(negedge CLK);
    check_value(tx_tvalid, 1'b0, "tx_tvalid after write");
  endtask

  task automatic test_read_and_pair();
    logic [26:0]  wa;
    logic [26:0]  ra;
    logic [255:0] d;
    logic [8:0]   tag;
    ra  = 27'($random(seed));
    tag = 9'($random(seed));
    send_requests(1'b0, 1'b1, '0, '0, ra, tag);
    check_value(tx_tvalid, 1'b1, "read tx_tvalid");
    check_value(tx_tdata, read_word(ra, tag), "read tx_tdata");
    check_value(tx_tuser, 12'h888, "read tx_tuser");
    // Write and read accepted together share one word
    wa  = 27'($random(seed));
    ra  = 27'($random(seed));
    d   = rand_data();
    tag = 9'($random(seed));
    send_requests(1'b1, 1'b1, wa, d, ra, tag);
    check_value(tx_tvalid, 1'b1, "pair tx_tvalid");
    check_value(tx_tdata, write_word(wa, d) | read_word(ra, tag), "pair tx_tdata");
    check_value(tx_tuser, 12'hc9f, "pair tx_tuser");
    @(negedge CLK);
  endtask

  task automatic test_backpressure();
    logic [26:0]  a;
    logic [26:0]  ra;
    logic [255:0] d;
    logic [8:0]   tag;
    a   = 27'($random(seed));
    ra  = 27'($random(seed));
    d   = rand_data();
    tag = 9'($random(seed));
    tx_tready = 1'b0;
    send_requests(1'b1, 1'b0, a, d, '0, '0);
    // A read waits while the write word is stalled
    rd_req  = 1'b1;
    rd_addr = ra;
    rd_tag  = tag;
    repeat (3) begin
      check_value(tx_tvalid, 1'b1, "stalled tx_tvalid");
      check_value(tx_tdata, write_word(a, d), "stalled tx_tdata");
      check_value(tx_tuser, 12'h417, "stalled tx_tuser");
      check_value(wr_ready, 1'b0, "wr_ready under stall");
      check_value(rd_ready, 1'b0, "rd_ready under stall");
      @(negedge CLK);
    end
    // Releasing the stall drains the word and the read takes its place
    tx_tready = 1'b1;
    @(negedge CLK);
    rd_req = 1'b0;
    check_value(tx_tdata, read_word(ra, tag), "read after stall");
    check_value(tx_tuser, 12'h888, "tuser after stall");
    @(negedge CLK);
    check_value(tx_tvalid, 1'b0, "tx_tvalid after drain");
  endtask

  // Three-FLIT response from head lane, split over two words for lanes 2 and 3
  task automatic send_response(input int lane, input bit gap);
    logic [255:0]  d;
    logic [8:0]    tag;
    logic [1023:0] flits;
    logic [7:0]    vld;
    logic [7:0]    hd;
    logic [7:0]    tl;
    d     = rand_data();
    tag   = 9'($random(seed));
    flits = '0;
    vld   = '0;
    hd    = '0;
    tl    = '0;
    flits[lane*128 +: 128]     = {d[63:0], make_header(RSP_CMD, 4'd3, '0, tag)};
    flits[(lane+1)*128 +: 128] = d[191:64];
    flits[(lane+2)*128 +: 128] = {64'd0, d[255:192]};
    vld[lane +: 3] = 3'b111;
    hd[lane]       = 1'b1;
    tl[lane+2]     = 1'b1;
    rx_tvalid = 1'b1;
    rx_tdata  = flits[511:0];
    rx_tuser  = {tl[3:0], hd[3:0], vld[3:0]};
    @(negedge CLK);
    if (lane >= 2) begin
      check_value(rsp_valid, 1'b0, "rsp_valid after head word");
      // Idle word with junk sideband must be skipped
      if (gap) begin
        rx_tvalid = 1'b0;
        rx_tdata  = {rand_data(), rand_data()};
        rx_tuser  = 12'($random(seed));
        @(negedge CLK);
        check_value(rsp_valid, 1'b0, "rsp_valid after idle word");
      end
      rx_tvalid = 1'b1;
      rx_tdata  = flits[1023:512];
      rx_tuser  = {tl[7:4], hd[7:4], vld[7:4]};
      @(negedge CLK);
    end
    rx_tvalid = 1'b0;
    rx_tdata  = '0;
    rx_tuser  = '0;
    check_value(rsp_valid, 1'b1, "rsp_valid after tail word");
    check_value(rsp_data, d, "rsp_data");
    check_value(rsp_tag, tag, "rsp_tag");
    @(negedge CLK);
    check_value(rsp_valid, 1'b0, "rsp_valid pulse end");
  endtask

  task automatic test_responses();
    send_response(0, 1'b0);
    send_response(1, 1'b0);
    send_response(2, 1'b0);
    send_response(3, 1'b1);
  endtask

//--- test/tb_hmc_user.sv
// --------------------------------------------------
// Testbench top: clock, reset, DUT, timeout,
// value checker and closing report
// --------------------------------------------------

`default_nettype none

module tb_hmc_user;

  // The whole directed run takes well under 100 cycles
  localparam int TIMEOUT_CYCLES = 1500;
  localparam int WAIT_LOG2      = 4;
  // Read response command code, only the tag field matters to the DUT
  localparam logic [5:0] RSP_CMD = 6'b111000;

  logic                          CLK;
  logic                          RST;
  logic                          post_done;
  logic                          wr_req;
  logic [hmc_pkg::ADDR_W-1:0]    wr_addr;
  logic [hmc_pkg::DATA_W-1:0]    wr_data;
  logic                          wr_ready;
  logic                          rd_req;
  logic [hmc_pkg::ADDR_W-1:0]    rd_addr;
  logic [hmc_pkg::TAG_W-1:0]     rd_tag;
  logic                          rd_ready;
  logic                          tx_tvalid;
  logic                          tx_tready;
  logic [hmc_pkg::BUS_W-1:0]     tx_tdata;
  hmc_pkg::flit_ctrl_t           tx_tuser;
  logic                          rx_tvalid;
  logic                          rx_tready;
  logic [hmc_pkg::BUS_W-1:0]     rx_tdata;
  hmc_pkg::flit_ctrl_t           rx_tuser;
  logic                          rsp_valid;
  logic [hmc_pkg::DATA_W-1:0]    rsp_data;
  logic [hmc_pkg::TAG_W-1:0]     rsp_tag;

  integer seed;
  int     err_cnt;
  int     chk_cnt;
  int     cycle_cnt;

  hmc_user_top #(
    .START_WAIT_LOG2 (WAIT_LOG2)
  ) i_hmc_user_top (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_ready_o  (wr_ready),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .tag_i       (rd_tag),
    .rd_ready_o  (rd_ready),
    .tx_tvalid_o (tx_tvalid),
    .tx_tready_i (tx_tready),
    .tx_tdata_o  (tx_tdata),
    .tx_tuser_o  (tx_tuser),
    .rx_tvalid_i (rx_tvalid),
    .rx_tready_o (rx_tready),
    .rx_tdata_i  (rx_tdata),
    .rx_tuser_i  (rx_tuser),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data),
    .rsp_tag_o   (rsp_tag)
  );

  // --------------------------------------------------
  // Clock and timeout
  // --------------------------------------------------
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // Compare one DUT output with its expected value
  task automatic check_value(input logic [511:0] got, input logic [511:0] exp,
                             input string what);
    chk_cnt = chk_cnt + 1;
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("Error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  `include "tb_hmc_user_tasks.svh"

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    seed      = 32'he4b5efa8;
    err_cnt   = 0;
    chk_cnt   = 0;
    RST       = 1'b1;
    post_done = 1'b0;
    wr_req    = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    rd_req    = 1'b0;
    rd_addr   = '0;
    rd_tag    = '0;
    tx_tready = 1'b1;
    rx_tvalid = 1'b0;
    rx_tdata  = '0;
    rx_tuser  = '0;
    // Two rising edges in reset, release on the falling edge
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    test_startup();
    test_write();
    test_read_and_pair();
    test_backpressure();
    test_responses();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+test
common/hmc_pkg.sv
tx/hmc_req_packer.sv
rx/hmc_rsp_locate.sv
rx/hmc_rsp_assemble.sv
verilog/hmc_user_top.sv
test/tb_hmc_user.sv

//--- Makefile
# Verilator lint and simulation for the HMC user side

VERILATOR ?= verilator
TOP       ?= tb_hmc_user
RTL_TOP   ?= hmc_user_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) test/tb_hmc_user_tasks.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
